/* design/direct_mapped_addr.sv */
`timescale 1ns/1ps
`default_nettype none

module direct_mapped_addr
    import mips_pkg::*;
(
    input  word_t i_vaddr,
    input  logic  i_k0_uncached,
    output word_t o_paddr,
    output logic  o_is_uncached
);

    logic is_kseg0;
    logic is_kseg1;

    assign is_kseg0 = (i_vaddr[31:29] == 3'b100);
    assign is_kseg1 = (i_vaddr[31:29] == 3'b101);

    // both segments alias the low 512 MB.
    assign o_paddr = {3'b000, i_vaddr[28:0]};

    // kseg1 never caches, kseg0 follows the config control.
    assign o_is_uncached = is_kseg1 || (is_kseg0 && i_k0_uncached);

endmodule

`default_nettype wire

/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // cache attribute code for uncached accesses.
    localparam logic [2:0] KSEG_UNCACHED_C = 3'b010;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  zero;
        logic [7:0]  asid;
    } cp0_entryhi_t;

    // tlbp looks up the raw register word as an address.
    typedef union packed {
        cp0_entryhi_t fields;
        word_t        raw;
    } cp0_entryhi_u;

    typedef struct packed {
        logic [5:0]  fill;
        logic [19:0] pfn;
        logic [2:0]  C;
        logic        D;
        logic        V;
        logic        G;
    } cp0_entrylo_t;

    typedef struct packed {
        logic        P;
        logic [26:0] zero;
        logic [3:0]  index;
    } cp0_index_t;

endpackage

`default_nettype wire

/* design/tlb.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb
    import mips_pkg::*, tlb_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,

    input  tlbwrite_t    i_tlbw,
    input  tlb_addr_t    i_read_addr,
    output tlb_entry_t   o_read_entry,

    input  logic [7:0]   i_asid,
    input  word_t        i_inst_vaddr,
    input  word_t        i_data_vaddr,
    input  word_t        i_probe_vaddr,
    output tlblut_resp_t o_inst_resp,
    output tlblut_resp_t o_data_resp,
    output cp0_index_t   o_probe_index
);

    tlb_table_t   tlb_table;
    tlblut_resp_t probe_resp;

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        always_ff @(posedge clk) begin
            if (!resetn) begin
                tlb_table[i] <= '0;
            end else if (i_tlbw.valid && (i_tlbw.addr == tlb_addr_t'(i))) begin
                tlb_table[i] <= i_tlbw.data;
            end
        end
    end

    assign o_read_entry = tlb_table[i_read_addr];

    tlb_lut u_inst_lut (
        .i_tlb_table (tlb_table),
        .i_vaddr     (i_inst_vaddr),
        .i_asid      (i_asid),
        .o_resp      (o_inst_resp)
    );

    tlb_lut u_data_lut (
        .i_tlb_table (tlb_table),
        .i_vaddr     (i_data_vaddr),
        .i_asid      (i_asid),
        .o_resp      (o_data_resp)
    );

    tlb_lut u_probe_lut (
        .i_tlb_table (tlb_table),
        .i_vaddr     (i_probe_vaddr),
        .i_asid      (i_asid),
        .o_resp      (probe_resp)
    );

    // P set means the probe found nothing.
    assign o_probe_index.P     = ~probe_resp.hit;
    assign o_probe_index.zero  = '0;
    assign o_probe_index.index = probe_resp.tlb_addr;

    a_write_known: assert property (
        @(posedge clk) disable iff (!resetn)
        !$isunknown(i_tlbw.valid)
    ) else $error("tlb: write valid is unknown");

endmodule

`default_nettype wire

/* design/tlb_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_lut
    import mips_pkg::*, tlb_pkg::*;
(
    input  tlb_table_t   i_tlb_table,
    input  word_t        i_vaddr,
    input  logic [7:0]   i_asid,
    output tlblut_resp_t o_resp
);

    logic [TLB_ENTRIES-1:0] hit_mask;
    logic [TLB_ENTRIES-1:0] valid_mask;
    tlb_addr_t              hit_addr;
    tlb_entry_t             sel_entry;
    logic                   odd_page;

    assign odd_page = i_vaddr[12];

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_match
        assign hit_mask[i] = (i_tlb_table[i].vpn2 == i_vaddr[31:13]) &&
                             (i_tlb_table[i].G || (i_tlb_table[i].asid == i_asid));
        assign valid_mask[i] = odd_page ? i_tlb_table[i].V1 : i_tlb_table[i].V0;
    end

    // lowest matching index wins.
    always_comb begin
        hit_addr = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit_mask[i]) begin
                hit_addr = tlb_addr_t'(i);
            end
        end
    end

    assign sel_entry = i_tlb_table[hit_addr];

    always_comb begin
        o_resp.hit      = |hit_mask;
        o_resp.tlb_addr = hit_addr;
        if (odd_page) begin
            o_resp.paddr      = {sel_entry.pfn1, i_vaddr[11:0]};
            o_resp.dirty      = sel_entry.D1;
            o_resp.valid      = sel_entry.V1;
            o_resp.cache_flag = sel_entry.C1;
        end else begin
            o_resp.paddr      = {sel_entry.pfn0, i_vaddr[11:0]};
            o_resp.dirty      = sel_entry.D0;
            o_resp.valid      = sel_entry.V0;
            o_resp.cache_flag = sel_entry.C0;
        end
    end

    // reset leaves all entries at vpn2 0, so only valid pages count.
    a_single_match: assert property (
        @(posedge tlb.clk) disable iff (!tlb.resetn)
        $onehot0(hit_mask & valid_mask)
    ) else $error("tlb_lut: more than one valid entry matches %h", i_vaddr);

endmodule

`default_nettype wire

/* design/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    import mips_pkg::*;

    localparam int TLB_ENTRIES = 16;

    typedef logic [$clog2(TLB_ENTRIES)-1:0] tlb_addr_t;

    // one entry maps an even/odd pair of 4 KB pages.
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        G;
        logic [19:0] pfn0;
        logic [2:0]  C0;
        logic        D0;
        logic        V0;
        logic [19:0] pfn1;
        logic [2:0]  C1;
        logic        D1;
        logic        V1;
    } tlb_entry_t;

    typedef tlb_entry_t [TLB_ENTRIES-1:0] tlb_table_t;

    typedef struct packed {
        logic       valid;
        tlb_addr_t  addr;
        tlb_entry_t data;
    } tlbwrite_t;

    typedef struct packed {
        logic       hit;
        tlb_addr_t  tlb_addr;
        word_t      paddr;
        logic       dirty;
        logic       valid;
        logic [2:0] cache_flag;
    } tlblut_resp_t;

    typedef struct packed {
        word_t vaddr;
        logic  is_store;
    } tu_addr_req_t;

    typedef struct packed {
        word_t paddr;
        logic  is_uncached;
        logic  refill;
        logic  invalid;
        logic  modified;
    } tu_addr_resp_t;

    typedef struct packed {
        logic         is_tlbwi;
        cp0_index_t   index;
        cp0_entryhi_u entryhi;
        cp0_entrylo_t entrylo0;
        cp0_entrylo_t entrylo1;
    } tu_op_req_t;

    typedef struct packed {
        cp0_index_t   index;
        cp0_entryhi_t entryhi;
        cp0_entrylo_t entrylo0;
        cp0_entrylo_t entrylo1;
    } tu_op_resp_t;

endpackage

`default_nettype wire

/* design/translation_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module translation_unit
    import mips_pkg::*, tlb_pkg::*;
(
    input  logic          clk,
    input  logic          resetn,
    input  logic          i_k0_uncached,

    input  tu_addr_req_t  i_i_req,
    input  tu_addr_req_t  i_d_req,
    output tu_addr_resp_t o_i_resp,
    output tu_addr_resp_t o_d_resp,

    input  tu_op_req_t    i_op_req,
    output tu_op_resp_t   o_op_resp
);

    word_t        i_direct_paddr;
    word_t        d_direct_paddr;
    logic         i_direct_uncached;
    logic         d_direct_uncached;
    tlblut_resp_t i_lut_resp;
    tlblut_resp_t d_lut_resp;
    tlbwrite_t    tlbw;
    tlb_entry_t   read_entry;
    cp0_index_t   probe_index;

    // kuseg, kseg2 and kseg3 go through the tlb.
    function automatic tu_addr_resp_t build_resp(
        input tu_addr_req_t req,
        input word_t        direct_paddr,
        input logic         direct_uncached,
        input tlblut_resp_t lut
    );
        tu_addr_resp_t resp;
        logic          mapped;
        mapped = !req.vaddr[31] || (req.vaddr[31:30] == 2'b11);
        resp = '0;
        if (mapped) begin
            resp.paddr       = lut.paddr;
            resp.is_uncached = (lut.cache_flag == KSEG_UNCACHED_C);
            resp.refill      = !lut.hit;
            resp.invalid     = lut.hit && !lut.valid;
            resp.modified    = lut.hit && lut.valid && req.is_store && !lut.dirty;
        end else begin
            resp.paddr       = direct_paddr;
            resp.is_uncached = direct_uncached;
        end
        return resp;
    endfunction

    direct_mapped_addr u_i_direct (
        .i_vaddr       (i_i_req.vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_paddr       (i_direct_paddr),
        .o_is_uncached (i_direct_uncached)
    );

    direct_mapped_addr u_d_direct (
        .i_vaddr       (i_d_req.vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_paddr       (d_direct_paddr),
        .o_is_uncached (d_direct_uncached)
    );

    assign o_i_resp = build_resp(i_i_req, i_direct_paddr, i_direct_uncached, i_lut_resp);
    assign o_d_resp = build_resp(i_d_req, d_direct_paddr, d_direct_uncached, d_lut_resp);

    // an entry is global only if both halves say so.
    always_comb begin
        tlbw.valid     = i_op_req.is_tlbwi;
        tlbw.addr      = i_op_req.index.index;
        tlbw.data.vpn2 = i_op_req.entryhi.fields.vpn2;
        tlbw.data.asid = i_op_req.entryhi.fields.asid;
        tlbw.data.G    = i_op_req.entrylo0.G & i_op_req.entrylo1.G;
        tlbw.data.pfn0 = i_op_req.entrylo0.pfn;
        tlbw.data.C0   = i_op_req.entrylo0.C;
        tlbw.data.D0   = i_op_req.entrylo0.D;
        tlbw.data.V0   = i_op_req.entrylo0.V;
        tlbw.data.pfn1 = i_op_req.entrylo1.pfn;
        tlbw.data.C1   = i_op_req.entrylo1.C;
        tlbw.data.D1   = i_op_req.entrylo1.D;
        tlbw.data.V1   = i_op_req.entrylo1.V;
    end

    tlb u_tlb (
        .clk           (clk),
        .resetn        (resetn),
        .i_tlbw        (tlbw),
        .i_read_addr   (i_op_req.index.index),
        .o_read_entry  (read_entry),
        .i_asid        (i_op_req.entryhi.fields.asid),
        .i_inst_vaddr  (i_i_req.vaddr),
        .i_data_vaddr  (i_d_req.vaddr),
        .i_probe_vaddr (i_op_req.entryhi.raw),
        .o_inst_resp   (i_lut_resp),
        .o_data_resp   (d_lut_resp),
        .o_probe_index (probe_index)
    );

    // tlbr result, G goes back to both halves.
    always_comb begin
        o_op_resp.index         = probe_index;
        o_op_resp.entryhi.vpn2  = read_entry.vpn2;
        o_op_resp.entryhi.zero  = '0;
        o_op_resp.entryhi.asid  = read_entry.asid;
        o_op_resp.entrylo0.fill = '0;
        o_op_resp.entrylo0.pfn  = read_entry.pfn0;
        o_op_resp.entrylo0.C    = read_entry.C0;
        o_op_resp.entrylo0.D    = read_entry.D0;
        o_op_resp.entrylo0.V    = read_entry.V0;
        o_op_resp.entrylo0.G    = read_entry.G;
        o_op_resp.entrylo1.fill = '0;
        o_op_resp.entrylo1.pfn  = read_entry.pfn1;
        o_op_resp.entrylo1.C    = read_entry.C1;
        o_op_resp.entrylo1.D    = read_entry.D1;
        o_op_resp.entrylo1.V    = read_entry.V1;
        o_op_resp.entrylo1.G    = read_entry.G;
    end

    // requests and the op index must be known once out of reset.
    a_req_known: assert property (
        @(posedge clk) disable iff (!resetn)
        !$isunknown({i_i_req, i_d_req, i_op_req.index.index})
    ) else $error("translation_unit: request or op index is unknown");

endmodule

`default_nettype wire

/* filelist.f */
design/mips_pkg.sv
design/tlb_pkg.sv
design/direct_mapped_addr.sv
design/tlb_lut.sv
design/tlb.sv
design/translation_unit.sv
testbench/tb_translation_unit.sv

/* testbench/tb_translation_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_translation_unit
    import mips_pkg::*, tlb_pkg::*;
();

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_OPS        = 144;
    localparam int TIMEOUT_NS   = (N_OPS + RESET_CYCLES) * CLK_NS * 2;

    logic          clk;
    logic          resetn;
    logic          k0_uncached;
    tu_addr_req_t  i_req;
    tu_addr_req_t  d_req;
    tu_addr_resp_t i_resp;
    tu_addr_resp_t d_resp;
    tu_op_req_t    op_req;
    tu_op_resp_t   op_resp;
    tlb_entry_t    model [TLB_ENTRIES];
    logic [15:0]   lfsr;
    int            n_errors = 0;
    int            n_checks = 0;

    translation_unit i_dut (
        .clk           (clk),
        .resetn        (resetn),
        .i_k0_uncached (k0_uncached),
        .i_i_req       (i_req),
        .i_d_req       (d_req),
        .o_i_resp      (i_resp),
        .o_d_resp      (d_resp),
        .i_op_req      (op_req),
        .o_op_resp     (op_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // first matching entry, -1 on a miss.
    function automatic int match_index(input word_t vaddr, input logic [7:0] asid);
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            if (model[k].vpn2 == vaddr[31:13] && (model[k].G || model[k].asid == asid)) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic tu_addr_resp_t expected_addr_resp(
        input tu_addr_req_t req,
        input logic         k0,
        input logic [7:0]   asid
    );
        tu_addr_resp_t r;
        tlb_entry_t    e;
        int            hit;
        logic          odd;
        r = '0;
        odd = req.vaddr[12];
        if (req.vaddr[31:30] == 2'b10) begin
            r.paddr = req.vaddr & 32'h1fff_ffff;
            r.is_uncached = req.vaddr[29] || k0;
            return r;
        end
        hit = match_index(req.vaddr, asid);
        if (hit < 0) begin
            r.refill = 1'b1;
            return r;
        end
        e = model[hit];
        r.paddr = {(odd ? e.pfn1 : e.pfn0), req.vaddr[11:0]};
        r.is_uncached = (odd ? e.C1 : e.C0) == KSEG_UNCACHED_C;
        r.invalid = !(odd ? e.V1 : e.V0);
        r.modified = !r.invalid && req.is_store && !(odd ? e.D1 : e.D0);
        return r;
    endfunction

    function automatic tu_op_resp_t expected_op_resp(input tu_op_req_t req);
        tu_op_resp_t r;
        tlb_entry_t  e;
        int          hit;
        r = '0;
        e = model[req.index.index];
        hit = match_index(req.entryhi.raw, req.entryhi.fields.asid);
        r.index.P = (hit < 0);
        r.index.index = (hit < 0) ? 4'd0 : 4'(hit);
        r.entryhi.vpn2 = e.vpn2;
        r.entryhi.asid = e.asid;
        r.entrylo0 = '{fill: 6'd0, pfn: e.pfn0, C: e.C0, D: e.D0, V: e.V0, G: e.G};
        r.entrylo1 = '{fill: 6'd0, pfn: e.pfn1, C: e.C1, D: e.D1, V: e.V1, G: e.G};
        return r;
    endfunction

    function automatic tlb_entry_t written_entry(input tu_op_req_t req);
        return '{vpn2: req.entryhi.fields.vpn2, asid: req.entryhi.fields.asid,
                 G: req.entrylo0.G & req.entrylo1.G,
                 pfn0: req.entrylo0.pfn, C0: req.entrylo0.C,
                 D0: req.entrylo0.D, V0: req.entrylo0.V,
                 pfn1: req.entrylo1.pfn, C1: req.entrylo1.C,
                 D1: req.entrylo1.D, V1: req.entrylo1.V};
    endfunction

    // a miss leaves paddr and cacheability open.
    function automatic logic addr_resp_ok(input tu_addr_resp_t got, input tu_addr_resp_t exp);
        if (exp.refill) begin
            return {got.refill, got.invalid, got.modified} === 3'b100;
        end
        return got === exp;
    endfunction

    function automatic logic op_resp_ok(input tu_op_resp_t got, input tu_op_resp_t exp);
        logic ok;
        ok = (got.entryhi === exp.entryhi) && (got.entrylo0 === exp.entrylo0) &&
             (got.entrylo1 === exp.entrylo1) && (got.index.P === exp.index.P) &&
             (got.index.zero === 27'd0);
        if (!exp.index.P) begin
            ok = ok && (got.index.index === exp.index.index);
        end
        return ok;
    endfunction

    // responses of the cycle that ends at this edge.
    always @(posedge clk) begin : compare
        tu_addr_resp_t exp_i;
        tu_addr_resp_t exp_d;
        tu_op_resp_t   exp_op;
        if (!resetn) begin
            for (int k = 0; k < TLB_ENTRIES; k++) begin
                model[k] <= '0;
            end
        end else begin
            exp_i = expected_addr_resp(i_req, k0_uncached, op_req.entryhi.fields.asid);
            exp_d = expected_addr_resp(d_req, k0_uncached, op_req.entryhi.fields.asid);
            exp_op = expected_op_resp(op_req);
            n_checks = n_checks + 3;
            a_i_resp: assert (addr_resp_ok(i_resp, exp_i)) else begin
                n_errors++;
                $display("error: %0d ns: fetch %h gave %h, expected %h",
                         $time, i_req.vaddr, i_resp, exp_i);
            end
            a_d_resp: assert (addr_resp_ok(d_resp, exp_d)) else begin
                n_errors++;
                $display("error: %0d ns: data %h gave %h, expected %h",
                         $time, d_req.vaddr, d_resp, exp_d);
            end
            a_op_resp: assert (op_resp_ok(op_resp, exp_op)) else begin
                n_errors++;
                $display("error: %0d ns: tlbr/tlbp gave %h, expected %h",
                         $time, op_resp, exp_op);
            end
            if (op_req.is_tlbwi) begin
                model[op_req.index.index] <= written_entry(op_req);
            end
        end
    end

    initial begin
        tlb_entry_t  ient;
        tlb_entry_t  dent;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        lfsr        = 16'd89;
        resetn      = 1'b0;
        k0_uncached = 1'b0;
        i_req       = '0;
        d_req       = '0;
        op_req      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        // cleared table, every index read back and mapped lookups.
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            op_req.index.index <= k[3:0];
            op_req.entryhi.raw <= {19'(rand_bits(19)), 5'd0, 8'(rand_bits(8))};
            i_req <= '{vaddr: {1'b0, 31'(rand_bits(31))}, is_store: 1'b0};
            d_req <= '{vaddr: {2'b11, 30'(rand_bits(30))}, is_store: 1'b1};
            @(posedge clk);
        end
        for (int k = 0; k < 32; k++) begin
            k0_uncached <= 1'(rand_bits(1));
            i_req.vaddr <= {2'b10, 30'(rand_bits(30))};
            d_req.vaddr <= {2'b10, 30'(rand_bits(30))};
            d_req.is_store <= 1'(rand_bits(1));
            @(posedge clk);
        end
        // tlbwi then tlbr of the same index.
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            vpn2 = {15'(rand_bits(15)), k[3:0]};
            vpn2[18] = vpn2[18] & vpn2[17];
            op_req.is_tlbwi <= 1'b1;
            op_req.index <= '{P: 1'b0, zero: 27'd0, index: k[3:0]};
            op_req.entryhi.raw <= {vpn2, 5'(rand_bits(5)), 8'(rand_bits(8))};
            op_req.entrylo0 <= rand_bits(32);
            op_req.entrylo1 <= rand_bits(32);
            @(posedge clk);
            op_req.is_tlbwi <= 1'b0;
            @(posedge clk);
        end
        // hits, asid mismatches and probes on the filled table.
        for (int k = 0; k < 64; k++) begin
            ient = model[4'(rand_bits(4))];
            dent = model[4'(rand_bits(4))];
            asid = rand_bits(1) ? ient.asid : 8'(rand_bits(8));
            i_req <= '{vaddr: {ient.vpn2, 13'(rand_bits(13))}, is_store: 1'b0};
            d_req <= '{vaddr: {dent.vpn2, 13'(rand_bits(13))}, is_store: 1'(rand_bits(1))};
            op_req.index.index <= 4'(rand_bits(4));
            op_req.entryhi.raw <= {(rand_bits(1) ? dent.vpn2 : 19'(rand_bits(19))), 5'd0, asid};
            @(posedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
